// ==== compile.f ====
+incdir+hdl
hdl/drp_pkg.sv
hdl/drp_cdc_sync.sv
hdl/drp_lb_regs.sv
hdl/drp_port_ctrl.sv
hdl/drp_bridge.sv
tb/drp_slave_model.sv
tb/tb_drp_bridge.sv

// ==== hdl/drp_bridge.sv ====
// DRP bridge top
// Local bus registers on the system clock, port controller on the DRP clock
// Command and feedback words cross through two word synchronizers
`timescale 1ns/100ps
`include "drp_defs.svh"

module drp_bridge
	import drp_pkg::*;
(
	input  logic                              SYS_RST_IN,
	input  logic                              SYS_CLK_IN,
	input  logic                              DRP_CLK_IN,

	// Local bus
	input  logic [`LB_ADR_W-1:0]              lb_adr,
	input  logic                              lb_wr,
	input  logic                              lb_rd,
	input  logic [`LB_DAT_W-1:0]              lb_din,
	output logic [`LB_DAT_W-1:0]              lb_dout,
	output logic                              lb_vld,

	// DRP ports, flattened
	output logic [`DRP_PORTS*`DRP_ADR_W-1:0]  drp_adr,
	output logic [`DRP_PORTS*`DRP_DAT_W-1:0]  drp_dat_out,
	output logic [`DRP_PORTS-1:0]             drp_en,
	output logic [`DRP_PORTS-1:0]             drp_wr,
	input  logic [`DRP_PORTS*`DRP_DAT_W-1:0]  drp_dat_in,
	input  logic [`DRP_PORTS-1:0]             drp_rdy
);

	drp_cmd_t cmd_sys;    // Held command, system side
	drp_cmd_t cmd_drp;    // Same word, DRP side
	drp_fb_t  fb_drp;
	drp_fb_t  fb_sys;

	drp_lb_regs lb_regs_inst
	(
		.SYS_RST_IN  (SYS_RST_IN),
		.SYS_CLK_IN  (SYS_CLK_IN),
		.lb_adr      (lb_adr),
		.lb_wr       (lb_wr),
		.lb_rd       (lb_rd),
		.lb_din      (lb_din),
		.lb_dout     (lb_dout),
		.lb_vld      (lb_vld),
		.cmd         (cmd_sys),
		.fb          (fb_sys)
	);

	// Command into the DRP clock
	drp_cdc_sync #(.payload_t(drp_cmd_t)) cmd_sync_inst
	(
		.SYS_RST_IN  (SYS_RST_IN),
		.dst_clk     (DRP_CLK_IN),
		.src_word    (cmd_sys),
		.dst_word    (cmd_drp)
	);

	drp_port_ctrl port_ctrl_inst
	(
		.SYS_RST_IN  (SYS_RST_IN),
		.DRP_CLK_IN  (DRP_CLK_IN),
		.cmd         (cmd_drp),
		.fb          (fb_drp),
		.drp_adr     (drp_adr),
		.drp_dat_out (drp_dat_out),
		.drp_en      (drp_en),
		.drp_wr      (drp_wr),
		.drp_dat_in  (drp_dat_in),
		.drp_rdy     (drp_rdy)
	);

	// Feedback back to the system clock
	drp_cdc_sync #(.payload_t(drp_fb_t)) fb_sync_inst
	(
		.SYS_RST_IN  (SYS_RST_IN),
		.dst_clk     (SYS_CLK_IN),
		.src_word    (fb_drp),
		.dst_word    (fb_sys)
	);

endmodule

// ==== hdl/drp_cdc_sync.sv ====
// Word synchronizer
// Two destination flops for a multi-bit word held stable by the source
// Safe only because the source holds the word far longer than two cycles
`timescale 1ns/100ps

module drp_cdc_sync
#(
	parameter type payload_t = logic
)
(
	input  logic     SYS_RST_IN,
	input  logic     dst_clk,
	input  payload_t src_word,
	output payload_t dst_word
);

	payload_t meta_word;    // First stage, may go metastable

	always_ff @(posedge dst_clk, posedge SYS_RST_IN)
	begin
		if (SYS_RST_IN)
		begin
			meta_word <= '0;
			dst_word  <= '0;
		end
		else
		begin
			meta_word <= src_word;
			dst_word  <= meta_word;    // Second stage, settled
		end
	end

endmodule

// ==== hdl/drp_defs.svh ====
// DRP bridge constants
// Port count, DRP and local bus widths, register map and field positions
`ifndef DRP_DEFS_SVH
`define DRP_DEFS_SVH

// DRP side
`define DRP_PORTS       5           // Transceiver ports served
`define DRP_PORT_W      3           // Port number width
`define DRP_ADR_W       10          // DRP address
`define DRP_DAT_W       16          // DRP data

// Local bus
`define LB_ADR_W        4
`define LB_DAT_W        32

// Register offsets, sized to the local bus address
`define REG_CTL         4'd0        // Control, self clearing
`define REG_STA         4'd1        // Status
`define REG_DAT         4'd2        // Command word in, read data out

// Bit positions
`define CTL_WR          0
`define CTL_RD          1
`define STA_BUSY        0
`define STA_RDY         1

// Data word fields, 29 bits used
`define DAT_PORT_LSB    0
`define DAT_ADR_LSB     3
`define DAT_DAT_LSB     13

`endif

// ==== hdl/drp_lb_regs.sv ====
// DRP bridge local bus registers
// Control, status and data registers on the system clock
// Builds the held command word and tracks busy and read ready from feedback
`timescale 1ns/100ps
`include "drp_defs.svh"

module drp_lb_regs
	import drp_pkg::*;
(
	input  logic                 SYS_RST_IN,
	input  logic                 SYS_CLK_IN,
	input  logic [`LB_ADR_W-1:0] lb_adr,
	input  logic                 lb_wr,
	input  logic                 lb_rd,
	input  logic [`LB_DAT_W-1:0] lb_din,
	output logic [`LB_DAT_W-1:0] lb_dout,
	output logic                 lb_vld,
	output drp_cmd_t             cmd,
	input  drp_fb_t              fb
);

	// Registered local bus
	logic [`LB_ADR_W-1:0]  adr_r;
	logic                  wr_r;
	logic                  rd_r;
	logic [`LB_DAT_W-1:0]  din_r;

	// Register selects
	logic                  ctl_sel;
	logic                  sta_sel;
	logic                  dat_sel;

	logic [1:0]            ctl_r;      // Write and read flags
	logic [1:0]            sta_r;
	logic                  busy;
	logic                  rdy;

	// Data register fields
	logic [`DRP_PORT_W-1:0] port_r;
	logic [`DRP_ADR_W-1:0]  drp_adr_r;
	logic [`DRP_DAT_W-1:0]  drp_dat_r;

	logic                  cmd_wr;     // Held until echo
	logic                  cmd_rd;

	// Feedback edge detection
	logic                  fb_wr_d;
	logic                  fb_rd_d;
	logic                  fb_rdy_d;
	logic                  fb_wr_re;
	logic                  fb_rd_re;
	logic                  fb_rdy_re;

	// Local bus strobes
	always_ff @(posedge SYS_CLK_IN, posedge SYS_RST_IN)
	begin
		if (SYS_RST_IN)
		begin
			wr_r <= 1'b0;
			rd_r <= 1'b0;
		end
		else
		begin
			wr_r <= lb_wr;
			rd_r <= lb_rd;
		end
	end

	always_ff @(posedge SYS_CLK_IN)
	begin
		adr_r <= lb_adr;
		din_r <= lb_din;
	end

	assign ctl_sel = (adr_r == `REG_CTL);
	assign sta_sel = (adr_r == `REG_STA);
	assign dat_sel = (adr_r == `REG_DAT);

	// Read mux, anything unmapped returns read data
	always_comb
	begin
		lb_dout = '0;
		if (ctl_sel)
			lb_dout[1:0] = ctl_r;
		else if (sta_sel)
			lb_dout[1:0] = sta_r;
		else
			lb_dout[`DRP_DAT_W-1:0] = fb.din;
	end

	assign lb_vld = rd_r;    // One cycle after the strobe

	// Control flags live for one cycle only
	always_ff @(posedge SYS_CLK_IN, posedge SYS_RST_IN)
	begin
		if (SYS_RST_IN)
			ctl_r <= 2'b00;
		else if (ctl_sel && wr_r)
		begin
			ctl_r[`CTL_WR] <= din_r[`CTL_WR];
			ctl_r[`CTL_RD] <= din_r[`CTL_RD];
		end
		else
			ctl_r <= 2'b00;    // Self clear
	end

	assign sta_r[`STA_BUSY] = busy;
	assign sta_r[`STA_RDY]  = rdy;

	// Port, address and write data
	always_ff @(posedge SYS_CLK_IN)
	begin
		if (dat_sel && wr_r)
		begin
			port_r    <= din_r[`DAT_PORT_LSB +: `DRP_PORT_W];
			drp_adr_r <= din_r[`DAT_ADR_LSB +: `DRP_ADR_W];
			drp_dat_r <= din_r[`DAT_DAT_LSB +: `DRP_DAT_W];
		end
	end

	// Previous feedback levels
	always_ff @(posedge SYS_CLK_IN, posedge SYS_RST_IN)
	begin
		if (SYS_RST_IN)
		begin
			fb_wr_d  <= 1'b0;
			fb_rd_d  <= 1'b0;
			fb_rdy_d <= 1'b0;
		end
		else
		begin
			fb_wr_d  <= fb.wr;
			fb_rd_d  <= fb.rd;
			fb_rdy_d <= fb.rdy;
		end
	end

	assign fb_wr_re  = fb.wr  & ~fb_wr_d;
	assign fb_rd_re  = fb.rd  & ~fb_rd_d;
	assign fb_rdy_re = fb.rdy & ~fb_rdy_d;

	// Command levels, set by flag, dropped on echo
	always_ff @(posedge SYS_CLK_IN, posedge SYS_RST_IN)
	begin
		if (SYS_RST_IN)
		begin
			cmd_wr <= 1'b0;
			cmd_rd <= 1'b0;
		end
		else
		begin
			if (ctl_r[`CTL_WR])
				cmd_wr <= 1'b1;
			else if (fb_wr_re)
				cmd_wr <= 1'b0;

			if (ctl_r[`CTL_RD])
				cmd_rd <= 1'b1;
			else if (fb_rd_re)
				cmd_rd <= 1'b0;
		end
	end

	// Busy trails the levels by one cycle
	// Ready is cleared by a new read or by writing 1
	always_ff @(posedge SYS_CLK_IN, posedge SYS_RST_IN)
	begin
		if (SYS_RST_IN)
		begin
			busy <= 1'b0;
			rdy  <= 1'b0;
		end
		else
		begin
			busy <= cmd_wr | cmd_rd;
			if (ctl_r[`CTL_RD] || (sta_sel && wr_r && din_r[`STA_RDY]))
				rdy <= 1'b0;
			else if (fb_rdy_re)
				rdy <= 1'b1;
		end
	end

	assign cmd.wr   = cmd_wr;
	assign cmd.rd   = cmd_rd;
	assign cmd.port = port_r;
	assign cmd.adr  = drp_adr_r;
	assign cmd.dat  = drp_dat_r;

endmodule

// ==== hdl/drp_pkg.sv ====
// DRP bridge types
// Command and feedback words that cross between the two clock domains
`include "drp_defs.svh"

package drp_pkg;

	// Command, system clock to DRP clock
	// wr and rd are levels held until the echo returns
	typedef struct packed
	{
		logic                    wr;     // Write request level
		logic                    rd;     // Read request level
		logic [`DRP_PORT_W-1:0]  port;   // Target port
		logic [`DRP_ADR_W-1:0]   adr;
		logic [`DRP_DAT_W-1:0]   dat;    // Write data
	} drp_cmd_t;

	// Feedback, DRP clock back to system clock
	typedef struct packed
	{
		logic                    wr;     // Echo of synchronized wr
		logic                    rd;     // Echo of synchronized rd
		logic                    rdy;    // Port answered since last command
		logic [`DRP_DAT_W-1:0]   din;    // Captured read data
	} drp_fb_t;

endpackage

// ==== hdl/drp_port_ctrl.sv ====
// DRP port controller
// Turns synchronized command levels into one enable pulse on the addressed port
// Captures read data on any port's ready edge and returns the feedback word
`timescale 1ns/100ps
`include "drp_defs.svh"

module drp_port_ctrl
	import drp_pkg::*;
(
	input  logic                              SYS_RST_IN,
	input  logic                              DRP_CLK_IN,
	input  drp_cmd_t                          cmd,
	output drp_fb_t                           fb,
	output logic [`DRP_PORTS*`DRP_ADR_W-1:0]  drp_adr,
	output logic [`DRP_PORTS*`DRP_DAT_W-1:0]  drp_dat_out,
	output logic [`DRP_PORTS-1:0]             drp_en,
	output logic [`DRP_PORTS-1:0]             drp_wr,
	input  logic [`DRP_PORTS*`DRP_DAT_W-1:0]  drp_dat_in,
	input  logic [`DRP_PORTS-1:0]             drp_rdy
);

	// Command edges
	logic                    cmd_wr_d;
	logic                    cmd_rd_d;
	logic                    wr_re;
	logic                    rd_re;
	logic                    start;      // Either edge

	logic [`DRP_PORTS-1:0]   port_hit;   // Decoded port number

	// Ready edges, one per port
	logic [`DRP_PORTS-1:0]   rdy_d;
	logic [`DRP_PORTS-1:0]   rdy_re;

	logic [`DRP_DAT_W-1:0]   din;        // Last captured read data
	logic                    fb_rdy;

	always_ff @(posedge DRP_CLK_IN, posedge SYS_RST_IN)
	begin
		if (SYS_RST_IN)
		begin
			cmd_wr_d <= 1'b0;
			cmd_rd_d <= 1'b0;
			rdy_d    <= '0;
		end
		else
		begin
			cmd_wr_d <= cmd.wr;
			cmd_rd_d <= cmd.rd;
			rdy_d    <= drp_rdy;
		end
	end

	assign wr_re  = cmd.wr & ~cmd_wr_d;
	assign rd_re  = cmd.rd & ~cmd_rd_d;
	assign start  = wr_re | rd_re;
	assign rdy_re = drp_rdy & ~rdy_d;

	always_comb
	begin
		for (int i = 0; i < `DRP_PORTS; i++)
			port_hit[i] = (cmd.port == `DRP_PORT_W'(i));
	end

	// One cycle enable on the selected port, write only for writes
	always_ff @(posedge DRP_CLK_IN, posedge SYS_RST_IN)
	begin
		if (SYS_RST_IN)
		begin
			drp_en <= '0;
			drp_wr <= '0;
		end
		else
		begin
			drp_en <= port_hit & {`DRP_PORTS{start}};
			drp_wr <= port_hit & {`DRP_PORTS{wr_re}};
		end
	end

	// Read data from whichever port answered
	always_ff @(posedge DRP_CLK_IN)
	begin
		for (int i = 0; i < `DRP_PORTS; i++)
		begin
			if (rdy_re[i])
				din <= drp_dat_in[i*`DRP_DAT_W +: `DRP_DAT_W];
		end
	end

	// Cleared at command start, set on any ready edge
	always_ff @(posedge DRP_CLK_IN, posedge SYS_RST_IN)
	begin
		if (SYS_RST_IN)
			fb_rdy <= 1'b0;
		else if (start)
			fb_rdy <= 1'b0;
		else if (|rdy_re)
			fb_rdy <= 1'b1;
	end

	// Echo levels so the system side can drop its command
	assign fb.wr  = cmd.wr;
	assign fb.rd  = cmd.rd;
	assign fb.rdy = fb_rdy;
	assign fb.din = din;

	// Address and data shared by all ports
	assign drp_adr     = {`DRP_PORTS{cmd.adr}};
	assign drp_dat_out = {`DRP_PORTS{cmd.dat}};

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the DRP bridge testbench with Verilator, run from the project root
verilator --binary --timing -f compile.f --top-module tb_drp_bridge -Mdir obj_dir \
	&& ./obj_dir/Vtb_drp_bridge | tee /dev/stderr | grep -q "Finished with no errors" \
	&& echo "RESULT: PASS" \
	|| { echo "RESULT: FAIL"; exit 1; }

// ==== tb/drp_cases.txt ====
# op port adr dat exp, all hex
# W: exp is status after the write; R: dat unused, exp is the read data
W 0 000 1234 0002
R 0 000 0 1234
W 1 000 BEEF 0002
R 1 000 0 BEEF
R 0 000 0 1234
W 4 3FF 1ABCD 0002
R 4 3FF 0 ABCD
R 1 3FF 0 A25A
W 2 155 5A5A 0002
R 2 155 0 5A5A
W 3 2AA FFFF 0002
R 3 2AA 0 FFFF
W 3 2AA 0000 0002
R 3 2AA 0 0000
R 2 005 0 ADA0
W 0 000 CAFE 0002
R 0 000 0 CAFE
R 1 000 0 BEEF
R 4 3FF 0 ABCD

// ==== tb/drp_slave_model.sv ====
// DRP port model
// One 1024 word memory per port, ready after a random 1 to 8 cycle delay
// Reports enables on several ports, repeated enables and writes without enable
`timescale 1ns/100ps
`include "drp_defs.svh"

module drp_slave_model
(
	input  logic                              SYS_RST_IN,
	input  logic                              DRP_CLK_IN,
	input  logic [`DRP_PORTS*`DRP_ADR_W-1:0]  drp_adr,
	input  logic [`DRP_PORTS*`DRP_DAT_W-1:0]  drp_dat_out,
	input  logic [`DRP_PORTS-1:0]             drp_en,
	input  logic [`DRP_PORTS-1:0]             drp_wr,
	output logic [`DRP_PORTS*`DRP_DAT_W-1:0]  drp_dat_in,
	output logic [`DRP_PORTS-1:0]             drp_rdy,
	output logic                              proto_err    // Sticky
);

	logic [`DRP_DAT_W-1:0]  mem [`DRP_PORTS][1024];
	logic [`DRP_ADR_W-1:0]  held_adr [`DRP_PORTS];    // Address seen with enable
	logic [3:0]             cnt [`DRP_PORTS];         // Cycles left to ready
	logic [`DRP_PORTS-1:0]  pending;

	always @(posedge DRP_CLK_IN, posedge SYS_RST_IN)
	begin
		if (SYS_RST_IN)
		begin
			drp_rdy    <= '0;
			drp_dat_in <= '0;
			pending    <= '0;
			proto_err  <= 1'b0;
			for (int p = 0; p < `DRP_PORTS; p++)
			begin
				cnt[p]      <= 4'd0;
				held_adr[p] <= '0;
				for (int a = 0; a < 1024; a++)
					mem[p][a] <= 16'({3'(p), 10'(a)}) ^ 16'hA5A5;    // Port and address
			end
		end
		else
		begin
			for (int p = 0; p < `DRP_PORTS; p++)
			begin
				drp_rdy[p] <= 1'b0;
				if (drp_en[p])
				begin
					if ($countones(drp_en) != 1)
					begin
						$display("DRP enable seen on more than one port at %0t", $time);
						proto_err <= 1'b1;
					end
					if (pending[p])
					begin
						$display("Second DRP enable on port %0d before ready", p);
						proto_err <= 1'b1;
					end
					pending[p]  <= 1'b1;
					held_adr[p] <= drp_adr[p*`DRP_ADR_W +: `DRP_ADR_W];
					cnt[p]      <= 4'(($urandom % 8) + 1);
					if (drp_wr[p])
						mem[p][drp_adr[p*`DRP_ADR_W +: `DRP_ADR_W]] <=
							drp_dat_out[p*`DRP_DAT_W +: `DRP_DAT_W];
				end
				else if (drp_wr[p])
				begin
					$display("DRP write without enable on port %0d", p);
					proto_err <= 1'b1;
				end
				else if (pending[p])
				begin
					if (cnt[p] == 4'd1)
					begin
						drp_rdy[p]                            <= 1'b1;
						drp_dat_in[p*`DRP_DAT_W +: `DRP_DAT_W] <= mem[p][held_adr[p]];
						pending[p]                            <= 1'b0;
					end
					else
						cnt[p] <= cnt[p] - 4'd1;
				end
			end
		end
	end

endmodule

// ==== tb/tb_drp_bridge.sv ====
// DRP bridge testbench
// Runs the operations of the case file through the local bus and checks results
`timescale 1ns/100ps
`include "drp_defs.svh"

module tb_drp_bridge;

	logic                              SYS_RST_IN;
	logic                              SYS_CLK_IN;
	logic                              DRP_CLK_IN;
	logic [`LB_ADR_W-1:0]              lb_adr;
	logic                              lb_wr;
	logic                              lb_rd;
	logic [`LB_DAT_W-1:0]              lb_din;
	logic [`LB_DAT_W-1:0]              lb_dout;
	logic                              lb_vld;
	logic [`DRP_PORTS*`DRP_ADR_W-1:0]  drp_adr;
	logic [`DRP_PORTS*`DRP_DAT_W-1:0]  drp_dat_out;
	logic [`DRP_PORTS-1:0]             drp_en;
	logic [`DRP_PORTS-1:0]             drp_wr;
	logic [`DRP_PORTS*`DRP_DAT_W-1:0]  drp_dat_in;
	logic [`DRP_PORTS-1:0]             drp_rdy;
	logic                              proto_err;
	logic [`DRP_PORT_W-1:0]            cur_port;    // Port of the running case

	drp_bridge drp_bridge_inst (.*);
	drp_slave_model slave_model_inst (.*);

	initial
	begin
		SYS_CLK_IN = 1'b0;
		forever #50 SYS_CLK_IN = ~SYS_CLK_IN;
	end

	initial
	begin
		DRP_CLK_IN = 1'b0;
		forever #35 DRP_CLK_IN = ~DRP_CLK_IN;    // Unrelated to the system clock
	end

	task automatic abort_run(input string what);
		$display("Run stopped: %s", what);
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("ERR %s got 0x%08h expected 0x%08h", name, got, exp);
			$display("Finished with errors");
			$fatal(1);
		end
	endtask

	task automatic lb_write_reg(input logic [3:0] adr, input logic [31:0] dat);
		@(posedge SYS_CLK_IN);
		lb_adr <= adr;
		lb_din <= dat;
		lb_wr  <= 1'b1;
		@(posedge SYS_CLK_IN);
		lb_wr  <= 1'b0;
	endtask

	// Result sampled at the falling edge while lb_vld is high
	task automatic lb_read_reg(input logic [3:0] adr, output logic [31:0] val);
		int tries;
		tries = 0;
		@(posedge SYS_CLK_IN);
		lb_adr <= adr;
		lb_rd  <= 1'b1;
		@(posedge SYS_CLK_IN);
		lb_rd  <= 1'b0;
		@(negedge SYS_CLK_IN);
		while (lb_vld !== 1'b1)
		begin
			tries++;
			if (tries > 4)
				abort_run("lb_vld never rose after a local bus read");
			else
				@(negedge SYS_CLK_IN);
		end
		val = lb_dout;
	endtask

	// Poll status until one bit reaches a level
	task automatic poll_status(input int bit_pos, input logic level, input string what,
		output logic [31:0] val);
		int tries;
		tries = 0;
		lb_read_reg(`REG_STA, val);
		while (val[bit_pos] !== level)
		begin
			tries++;
			if (tries > 100)
				abort_run(what);
			else
				lb_read_reg(`REG_STA, val);
		end
	endtask

	task automatic clear_ready();
		logic [31:0] val;
		lb_write_reg(`REG_STA, 32'(1) << `STA_RDY);
		lb_read_reg(`REG_STA, val);
		check_val("sta after ready clear", val, 32'h0);
	endtask

	task automatic run_case(input byte op, input logic [31:0] port, input logic [31:0] adr,
		input logic [31:0] dat, input logic [31:0] exp);
		logic [31:0] word;
		logic [31:0] val;
		cur_port = port[`DRP_PORT_W-1:0];
		if (op == "W")
			clear_ready();    // A new read clears ready by itself
		word = (port & 32'h7) | ((adr & 32'h3FF) << `DAT_ADR_LSB) | (dat << `DAT_DAT_LSB);
		lb_write_reg(`REG_DAT, word);
		if (op == "W")
			lb_write_reg(`REG_CTL, 32'(1) << `CTL_WR);
		else
			lb_write_reg(`REG_CTL, 32'(1) << `CTL_RD);
		poll_status(`STA_BUSY, 1'b1, "busy never rose after a command", val);
		check_val("sta_rdy while busy", 32'(val[`STA_RDY]), 32'h0);
		poll_status(`STA_BUSY, 1'b0, "busy never fell after a command", val);
		poll_status(`STA_RDY, 1'b1, "ready never rose after a command", val);
		lb_read_reg(`REG_CTL, val);
		check_val("ctl after command", val, 32'h0);
		if (op == "W")
		begin
			lb_read_reg(`REG_STA, val);
			check_val("sta after write", val, exp);
		end
		else
		begin
			lb_read_reg(`REG_DAT, val);
			check_val("lb_dout read data", val, exp);
		end
	endtask

	// Enable must only ever hit the addressed port
	always @(negedge DRP_CLK_IN)
	begin
		if (!SYS_RST_IN && (drp_en != '0))
			check_val("drp_en", 32'(drp_en), 32'(1) << cur_port);
	end

	always @(posedge proto_err)
	begin
		$display("DRP port model saw a protocol violation");
		$display("Finished with errors");
		$fatal(1);
	end

	initial
	begin
		int fd;
		int n;
		byte op;
		logic [31:0] port;
		logic [31:0] adr;
		logic [31:0] dat;
		logic [31:0] exp;
		logic [31:0] val;
		string line;
		n = $urandom(53);
		SYS_RST_IN = 1'b1;
		lb_adr     = '0;
		lb_wr      = 1'b0;
		lb_rd      = 1'b0;
		lb_din     = '0;
		cur_port   = '0;
		repeat (8) @(posedge SYS_CLK_IN);
		SYS_RST_IN <= 1'b0;
		lb_read_reg(`REG_CTL, val);
		check_val("ctl after reset", val, 32'h0);
		lb_read_reg(`REG_STA, val);
		check_val("sta after reset", val, 32'h0);
		check_val("drp_en after reset", 32'(drp_en), 32'h0);
		check_val("drp_wr after reset", 32'(drp_wr), 32'h0);
		fd = $fopen("tb/drp_cases.txt", "r");
		if (fd == 0)
			abort_run("could not open tb/drp_cases.txt");
		while (!$feof(fd))
		begin
			n = $fgets(line, fd);
			if (n > 1 && line[0] != "#")
			begin
				n = $sscanf(line, "%c %h %h %h %h", op, port, adr, dat, exp);
				if (n == 5)
					run_case(op, port, adr, dat, exp);
			end
		end
		$fclose(fd);
		$display("Finished with no errors");
		$finish;
	end

endmodule
